// File: hdl/spectro_params.svh
`ifndef SPECTRO_PARAMS_SVH
`define SPECTRO_PARAMS_SVH

// FFT sample shape
`define NUM_BINS	32		// Bins read per sample
`define BIN_IDX_W	5
`define MAG_W		8
`define BIN_DEPTH	6		// Samples a bin can hold before copy
`define DEPTH_W		3

// Video and SRAM widths
`define COORD_W		10
`define SRAM_ADDR_W	18
`define SRAM_DATA_W	16

// Spectrogram region, one column per sample
`define SPEC_X0		20
`define SPEC_COLS	600
`define SPEC_Y_MAX	255

// Bar graph region
`define BAR_X0		64
`define BAR_X1		575
`define BAR_Y0		293
`define BAR_BASE	419		// Row the bars grow up from
`define BAR_SHIFT	4		// 16 pixels per bar

`define PERIOD_UNIT	42000	// Cycles per screen-length step
`endif

// File: hdl/spectro_pkg.sv
`include "spectro_params.svh"

package spectro_pkg;

	typedef enum logic [1:0] {
		CAP_START,
		CAP_READ,
		CAP_ADDR,
		CAP_WAIT
	} capture_state_e;

	typedef enum logic [1:0] {
		PH_DISPLAY,
		PH_COPY,
		PH_CAPTURE
	} sram_phase_e;

	typedef struct packed {
		logic [`COORD_W-1:0]	x;
		logic [`COORD_W-1:0]	y;
		logic					hs_n;
		logic					vs_n;
	} video_pos_t;

	typedef struct packed {
		logic [`SRAM_ADDR_W-1:0]	addr;
		logic [`SRAM_DATA_W-1:0]	wdata;
		logic						we_n;	// Active low write strobe
		logic						rsel;	// Upper or lower byte lane
	} sram_req_t;

	typedef struct packed {
		logic					valid;
		logic [`BIN_IDX_W-1:0]	bin;
		logic [`MAG_W-1:0]		mag;
	} bin_push_t;

endpackage

// File: hdl/sample_timer.sv
`timescale 1ns/1ns
`include "spectro_params.svh"

module sample_timer #(
	parameter int UNIT = `PERIOD_UNIT
) (
	input logic			VGA_CTRL_CLK,
	input logic			reset,
	input logic			run,
	input logic [2:0]	sw_period,
	input logic			done,
	output logic		tick
);

	logic [31:0]	period;
	logic [31:0]	acc;
	logic			sub_pend;	// Capture answered last cycle

	// Two to nine units of screen time
	assign period = (32'(sw_period) + 32'd2) * 32'(UNIT);

	assign tick = (acc >= period) && !sub_pend;

	always_ff @(posedge VGA_CTRL_CLK) begin
		if (reset) begin
			acc <= '0;
			sub_pend <= 1'b0;
		end else begin
			sub_pend <= done;
			if (sub_pend) begin
				// Remainder carries over so the mean rate stays exact
				acc <= acc + 32'(run) - period;
			end else if (run) begin
				acc <= acc + 32'd1;
			end
		end
	end

endmodule

// File: hdl/capture_fsm.sv
`timescale 1ns/1ns
`include "spectro_params.svh"

module capture_fsm (
	input logic						VGA_CTRL_CLK,
	input logic						reset,
	input logic						capture_en,
	input logic						tick,
	input logic						fft_ready,
	input logic [`MAG_W-1:0]		fft_mag,
	input logic [`DEPTH_W-1:0]		count,
	output logic					fft_hold,
	output logic [`BIN_IDX_W-1:0]	fft_bin,
	output spectro_pkg::bin_push_t	push,
	output logic					push_last,
	output logic					done
);
	import spectro_pkg::*;

	capture_state_e	state;
	logic			ready_0;
	logic			ready_1;
	logic			full;
	logic			read_last;

	assign full = (count == `DEPTH_W'(`BIN_DEPTH));
	assign read_last = capture_en && (state == CAP_READ) &&
		(fft_bin == `BIN_IDX_W'(`NUM_BINS - 1));

	assign push.valid = capture_en && (state == CAP_READ);
	assign push.bin = fft_bin;
	assign push.mag = fft_mag;
	assign push_last = read_last;
	// A full store answers the tick at once and drops the sample
	assign done = read_last || (capture_en && (state == CAP_WAIT) && tick && full);

	always_ff @(posedge VGA_CTRL_CLK) begin
		ready_0 <= fft_ready;	// FFT runs on its own clock
		ready_1 <= ready_0;
	end

	always_ff @(posedge VGA_CTRL_CLK) begin
		if (reset) begin
			state <= CAP_WAIT;
			fft_hold <= 1'b0;
			fft_bin <= '0;
		end else if (capture_en) begin
			case (state)
				CAP_WAIT: begin
					if (tick && !full) state <= CAP_START;
				end
				CAP_START: begin
					fft_hold <= 1'b1;	// Freeze FFT output
					fft_bin <= '0;
					if (ready_1) state <= CAP_READ;
				end
				CAP_READ: begin
					if (fft_bin == `BIN_IDX_W'(`NUM_BINS - 1)) begin
						fft_hold <= 1'b0;
						state <= CAP_WAIT;
					end else begin
						state <= CAP_ADDR;
					end
				end
				default: begin
					fft_bin <= fft_bin + 1'b1;	// Next bin settles here
					state <= CAP_READ;
				end
			endcase
		end
	end

endmodule

// File: hdl/bin_store.sv
`timescale 1ns/1ns
`include "spectro_params.svh"

module bin_store (
	input logic						VGA_CTRL_CLK,
	input logic						reset,
	input spectro_pkg::bin_push_t	push,
	input logic						push_last,
	input logic						pop,
	input logic						pop_last,
	input logic [`BIN_IDX_W-1:0]	pop_bin,
	input logic [`BIN_IDX_W-1:0]	bar_bin,
	output logic [`DEPTH_W-1:0]		count,
	output logic [`MAG_W-1:0]		head_mag,
	output logic [`MAG_W-1:0]		bar_level
);

	localparam int QUEUE_W = `BIN_DEPTH * `MAG_W;

	logic [QUEUE_W-1:0]	queue [`NUM_BINS];	// Oldest byte at the bottom
	logic				inc;
	logic				dec;

	assign inc = push.valid && push_last;
	assign dec = pop_last && (count != '0);

	//////////////////////////////////////////////////////////////////////////////
	// Byte queues

	always_ff @(posedge VGA_CTRL_CLK) begin
		if (pop && (count > `DEPTH_W'(1))) begin
			// Last pending sample stays put and feeds the bars
			queue[pop_bin] <= queue[pop_bin] >> `MAG_W;
		end
		if (push.valid) begin
			queue[push.bin][count * `MAG_W +: `MAG_W] <= push.mag;
		end
	end

	assign head_mag = queue[pop_bin][`MAG_W-1:0];
	assign bar_level = queue[bar_bin][`MAG_W-1:0];

	//////////////////////////////////////////////////////////////////////////////
	// Pending sample count

	always_ff @(posedge VGA_CTRL_CLK) begin
		if (reset) begin
			count <= '0;
		end else if (inc && !dec) begin
			count <= count + 1'b1;
		end else if (dec && !inc) begin
			count <= count - 1'b1;
		end
	end

endmodule

// File: hdl/display_addresser.sv
`timescale 1ns/1ns
`include "spectro_params.svh"

module display_addresser (
	input spectro_pkg::video_pos_t	pos,
	input logic [`COORD_W-1:0]		offset,
	input logic [`MAG_W-1:0]		bar_level,
	output logic [`BIN_IDX_W-1:0]	bar_bin,
	output spectro_pkg::sram_req_t	next_req
);

	logic [`COORD_W-1:0]		bar_dx;
	logic [`COORD_W-1:0]		bar_top;
	logic [`COORD_W-1:0]		new_col;	// Column written last
	logic [`COORD_W:0]			scroll_sum;
	logic [`COORD_W-1:0]		scroll_col;
	logic						in_bar;
	logic						in_spec;
	logic [`SRAM_ADDR_W-1:0]	pixel_addr;

	assign bar_dx = pos.x - `COORD_W'(`BAR_X0);
	assign bar_bin = bar_dx[`BAR_SHIFT +: `BIN_IDX_W];
	assign bar_top = `COORD_W'(`BAR_BASE) - `COORD_W'(bar_level[`MAG_W-1:1]);	// Half height
	assign new_col = (offset == '0) ? `COORD_W'(`SPEC_X0 + `SPEC_COLS - 1) :
		`COORD_W'(`SPEC_X0) + offset - 1'b1;

	// Oldest column shows at the left edge
	assign scroll_sum = {1'b0, pos.x} + {1'b0, offset};
	assign scroll_col = (scroll_sum >= (`COORD_W+1)'(`SPEC_X0 + `SPEC_COLS)) ?
		`COORD_W'(scroll_sum - (`COORD_W+1)'(`SPEC_COLS)) : scroll_sum[`COORD_W-1:0];

	assign in_bar = (pos.x >= `BAR_X0) && (pos.x <= `BAR_X1) &&
		(pos.y >= `BAR_Y0) && (pos.y < `BAR_BASE);
	assign in_spec = (pos.x >= `SPEC_X0) && (pos.x <= `SPEC_X0 + `SPEC_COLS - 1) &&
		(pos.y <= `SPEC_Y_MAX);
	assign pixel_addr = {pos.x, pos.y[8:1]};	// Two pixels per word

	always_comb begin
		next_req.wdata = '0;
		next_req.we_n = 1'b1;
		next_req.addr = pixel_addr;
		next_req.rsel = pos.y[0];
		if (in_bar) begin
			if (pos.y >= bar_top) begin
				next_req.addr = {new_col, 1'b0, `BIN_IDX_W'(`NUM_BINS - 1) - bar_bin, 2'b00};
				next_req.rsel = 1'b0;
			end
		end else if (in_spec) begin
			next_req.addr = {scroll_col, pos.y[8:3], 2'b00};	// 8 rows per bin
			next_req.rsel = 1'b0;
		end
	end

endmodule

// File: hdl/sram_scheduler.sv
`timescale 1ns/1ns
`include "spectro_params.svh"

module sram_scheduler (
	input logic						VGA_CTRL_CLK,
	input logic						reset,
	input logic						run,
	input spectro_pkg::video_pos_t	pos,
	input logic [`DEPTH_W-1:0]		count,
	input logic [`MAG_W-1:0]		head_mag,
	input spectro_pkg::sram_req_t	next_req,
	output logic					capture_en,
	output logic					pop,
	output logic					pop_last,
	output logic [`BIN_IDX_W-1:0]	pop_bin,
	output logic [`COORD_W-1:0]		offset,
	output spectro_pkg::sram_req_t	sram
);
	import spectro_pkg::*;

	sram_phase_e			phase;
	logic					win_open;	// Copy allowed in this vertical blank
	logic					copy_step;	// Low on write cycle, high on step cycle
	logic					last_bin;
	logic [`COORD_W-1:0]	copy_col;

	assign last_bin = (pop_bin == `BIN_IDX_W'(`NUM_BINS - 1));
	assign copy_col = `COORD_W'(`SPEC_X0) + offset;

	always_comb begin
		if (run && !pos.vs_n && win_open && (count != '0)) begin
			phase = PH_COPY;
		end else if (run && (!pos.hs_n || !pos.vs_n)) begin
			phase = PH_CAPTURE;	// Blanking left for the FFT reads
		end else begin
			phase = PH_DISPLAY;
		end
	end

	assign capture_en = (phase == PH_CAPTURE);
	assign pop = (phase == PH_COPY) && !copy_step;
	assign pop_last = (phase == PH_COPY) && copy_step && last_bin;

	//////////////////////////////////////////////////////////////////////////////
	// Column copy engine

	always_ff @(posedge VGA_CTRL_CLK) begin
		if (reset) begin
			win_open <= 1'b0;
			copy_step <= 1'b0;
			pop_bin <= '0;
			offset <= '0;
		end else begin
			if (!pos.hs_n && pos.vs_n) begin
				win_open <= 1'b1;
			end else if (!pos.vs_n && (count == '0)) begin
				win_open <= 1'b0;	// Store drained
			end
			if (phase == PH_COPY) begin
				copy_step <= !copy_step;
				if (copy_step) begin
					pop_bin <= pop_bin + 1'b1;
					if (last_bin) begin
						offset <= (offset == `COORD_W'(`SPEC_COLS - 1)) ? '0 : offset + 1'b1;
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////////
	// SRAM request register

	always_ff @(posedge VGA_CTRL_CLK) begin
		if (reset) begin
			sram.we_n <= 1'b1;
		end else begin
			case (phase)
				PH_COPY: begin
					if (!copy_step) begin
						// High bins at the top of the column
						sram.addr <= {copy_col, 1'b0,
							`BIN_IDX_W'(`NUM_BINS - 1) - pop_bin, 2'b00};
						sram.wdata <= {{(`SRAM_DATA_W - `MAG_W){1'b0}}, head_mag};
						sram.we_n <= 1'b0;
						sram.rsel <= 1'b0;
					end else begin
						sram.we_n <= 1'b1;
					end
				end
				PH_CAPTURE: sram.we_n <= 1'b1;
				default: sram <= next_req;
			endcase
		end
	end

endmodule

// File: hdl/spectro_top.sv
`timescale 1ns/1ns
`include "spectro_params.svh"

module spectro_top #(
	parameter int UNIT = `PERIOD_UNIT
) (
	input logic						VGA_CTRL_CLK,
	input logic						reset,
	input logic [2:0]				sw_period,
	input logic						run,
	input logic						fft_ready,
	input logic [`MAG_W-1:0]		fft_mag,
	input spectro_pkg::video_pos_t	pos,
	output logic					fft_hold,
	output logic [`BIN_IDX_W-1:0]	fft_bin,
	output spectro_pkg::sram_req_t	sram
);
	import spectro_pkg::*;

	logic					tick;
	logic					done;
	bin_push_t				push;
	logic					push_last;
	logic					capture_en;
	logic					pop;
	logic					pop_last;
	logic [`BIN_IDX_W-1:0]	pop_bin;
	logic [`BIN_IDX_W-1:0]	bar_bin;
	logic [`DEPTH_W-1:0]	count;
	logic [`MAG_W-1:0]		head_mag;
	logic [`MAG_W-1:0]		bar_level;
	logic [`COORD_W-1:0]	offset;
	sram_req_t				next_req;

	//////////////////////////////////////////////////////////////////////////////
	// Input side

	sample_timer #(.UNIT(UNIT)) u_timer (.VGA_CTRL_CLK, .reset, .run, .sw_period,
		.done, .tick);

	capture_fsm u_capture (.VGA_CTRL_CLK, .reset, .capture_en, .tick, .fft_ready,
		.fft_mag, .count, .fft_hold, .fft_bin, .push, .push_last, .done);

	//////////////////////////////////////////////////////////////////////////////
	// Processing

	bin_store u_store (.VGA_CTRL_CLK, .reset, .push, .push_last, .pop, .pop_last,
		.pop_bin, .bar_bin, .count, .head_mag, .bar_level);

	//////////////////////////////////////////////////////////////////////////////
	// Output side

	display_addresser u_addr (.pos, .offset, .bar_level, .bar_bin, .next_req);

	sram_scheduler u_sched (.VGA_CTRL_CLK, .reset, .run, .pos, .count, .head_mag,
		.next_req, .capture_en, .pop, .pop_last, .pop_bin, .offset, .sram);

endmodule

// File: testbench/spectro_sva.sv
`timescale 1ns/1ns

module spectro_sva #(
	parameter bit SCHED = 1'b1
) (
	input logic			VGA_CTRL_CLK,
	input logic			reset,
	input logic [1:0]	phase,
	input logic			we_n,
	input logic			capture_en,
	input logic			pop,
	input logic [1:0]	state,
	input logic [4:0]	fft_bin,
	input logic			push_last,
	input logic			fft_hold
);
	import spectro_pkg::*;

	if (SCHED) begin : g_sched
		// Strobe is registered, so it follows the phase by one cycle
		a_we_copy: assert property (@(posedge VGA_CTRL_CLK) disable iff (reset)
			!we_n |-> $past(phase) == PH_COPY)
			else $error("SRAM write outside the copy phase");
		a_no_overlap: assert property (@(posedge VGA_CTRL_CLK) disable iff (reset)
			!(capture_en && pop))
			else $error("Capture enabled during a pop");
	end else begin : g_capture
		a_bin_stable: assert property (@(posedge VGA_CTRL_CLK) disable iff (reset)
			state == CAP_READ |=> fft_bin == $past(fft_bin))
			else $error("fft_bin changed after a read cycle");
		a_hold_fall: assert property (@(posedge VGA_CTRL_CLK) disable iff (reset)
			push_last |=> $fell(fft_hold))
			else $error("fft_hold did not fall after the last bin");
	end

endmodule

bind sram_scheduler spectro_sva #(.SCHED(1'b1)) u_sva (.VGA_CTRL_CLK, .reset,
	.phase(phase), .we_n(sram.we_n), .capture_en, .pop, .state(2'b00),
	.fft_bin(5'd0), .push_last(1'b0), .fft_hold(1'b0));

bind capture_fsm spectro_sva #(.SCHED(1'b0)) u_sva (.VGA_CTRL_CLK, .reset,
	.phase(2'b00), .we_n(1'b1), .capture_en(1'b0), .pop(1'b0), .state(state),
	.fft_bin, .push_last, .fft_hold);

// File: testbench/tb_spectro.sv
`timescale 1ns/1ns
`include "spectro_params.svh"

module tb_spectro;
	import spectro_pkg::*;

	localparam int UNIT = 20;
	localparam int CYCLE_LIMIT = 20000;
	localparam int CAPTURE_LEN = 2 + 2 * `NUM_BINS;	// Tick to earliest next tick

	logic					VGA_CTRL_CLK;
	logic					reset;
	logic [2:0]				sw_period;
	logic					run;
	logic					fft_ready;
	logic [`MAG_W-1:0]		fft_mag;
	video_pos_t				pos;
	logic					fft_hold;
	logic [`BIN_IDX_W-1:0]	fft_bin;
	sram_req_t				sram;

	integer		seed = 25;
	int			cycles = 0;
	int			checks = 0;
	int			errors = 0;
	int			test_start = 0;
	int			sample_num = 0;	// Sample the FFT model presents
	int			hold_len = 0;	// Cycles since fft_hold rose
	logic		hold_q;
	logic		collect = 1'b0;
	logic		disp_on = 1'b0;
	logic		exp_valid = 1'b0;
	sram_req_t	exp_req;
	sram_req_t	writes [$];
	int			cur_offset;
	int			bar_sample;

	spectro_top #(.UNIT(UNIT)) DUT (.*);

	initial begin
		VGA_CTRL_CLK = 1'b0;
		forever #50 VGA_CTRL_CLK = ~VGA_CTRL_CLK;
	end

	always @(posedge VGA_CTRL_CLK) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// FFT model and reference functions

	function automatic logic [`MAG_W-1:0] model_mag(int bin, int sample);
		return `MAG_W'((bin * 7 + sample * 13) % 256);
	endfunction

	assign fft_mag = model_mag(fft_bin, sample_num);

	always @(posedge VGA_CTRL_CLK) begin
		hold_q <= fft_hold;
		if (reset) sample_num <= 0;
		else if (hold_q && !fft_hold) sample_num <= sample_num + 1;	// Next FFT frame
	end

	function automatic int ref_spacing(int sw);
		int p;
		p = (sw + 2) * UNIT;
		return (p >= CAPTURE_LEN) ? p : CAPTURE_LEN;	// Long capture stretches the period
	endfunction

	function automatic sram_req_t ref_copy_req(int offset, int bin, logic [`MAG_W-1:0] mag);
		sram_req_t r;
		r.addr = {10'(`SPEC_X0 + offset), 1'b0, 5'(`NUM_BINS - 1 - bin), 2'b00};
		r.wdata = 16'(mag);
		r.we_n = 1'b0;
		r.rsel = 1'b0;
		return r;
	endfunction

	function automatic sram_req_t ref_display_req(video_pos_t p, int offset, int sample);
		sram_req_t r;
		int x;
		int y;
		int bin;
		int col;
		x = p.x;
		y = p.y;
		r.wdata = '0;
		r.we_n = 1'b1;
		r.addr = {p.x, p.y[8:1]};	// Plain pixel pair
		r.rsel = p.y[0];
		if (x >= `BAR_X0 && x <= `BAR_X1 && y >= `BAR_Y0 && y < `BAR_BASE) begin
			bin = (x - `BAR_X0) >> `BAR_SHIFT;
			if (y >= `BAR_BASE - model_mag(bin, sample) / 2) begin
				col = (offset == 0) ? `SPEC_X0 + `SPEC_COLS - 1 : `SPEC_X0 + offset - 1;
				r.addr = {10'(col), 1'b0, 5'(`NUM_BINS - 1 - bin), 2'b00};
				r.rsel = 1'b0;
			end
		end else if (x >= `SPEC_X0 && x <= `SPEC_X0 + `SPEC_COLS - 1 && y <= `SPEC_Y_MAX) begin
			col = x + offset;
			if (col >= `SPEC_X0 + `SPEC_COLS) col = col - `SPEC_COLS;
			r.addr = {10'(col), p.y[8:3], 2'b00};
			r.rsel = 1'b0;
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks and helpers

	task automatic check_req(string name, sram_req_t got, sram_req_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_mag(string name, logic [`MAG_W-1:0] got, logic [`MAG_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_fail(string what);
		errors++;
		$display("Failure: %s", what);
	endtask

	task automatic step();
		@(posedge VGA_CTRL_CLK);
		#10;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (2) step();
		reset = 1'b0;
	endtask

	task automatic wait_hold_edge(bit rising, int limit, output int at);
		logic prev;
		int n;
		at = -1;
		n = 0;
		prev = fft_hold;
		while (at < 0 && n < limit) begin
			step();
			if (fft_hold == rising && prev != rising) at = cycles;
			prev = fft_hold;
			n++;
		end
	endtask

	task automatic end_test(string name);
		$display("Test %s: %s", name, (errors == test_start) ? "passed" : "failed");
		test_start = errors;
	endtask

	// One cycle behind pos, so last cycle's expectation is checked
	always @(negedge VGA_CTRL_CLK) begin
		if (exp_valid) check_req("sram", sram, exp_req);
		exp_req = ref_display_req(pos, cur_offset, bar_sample);
		exp_valid = disp_on;
		if (collect && sram.we_n === 1'b0) writes.push_back(sram);
		// Two cycles per bin while the FFT output is frozen
		if (fft_hold === 1'b1) begin
			check_count("fft_bin", int'(fft_bin), hold_len / 2);
			hold_len++;
		end else begin
			hold_len = 0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Tests

	initial begin
		int t [3];
		int at;
		int rises;
		int n;
		int r;
		int sw_list [2];
		sram_req_t w;
		reset = 1'b1;
		sw_period = 3'd3;
		run = 1'b1;
		fft_ready = 1'b1;
		pos = '{x: '0, y: '0, hs_n: 1'b1, vs_n: 1'b1};
		sw_list = '{0, 3};

		apply_reset();
		repeat ((3 + 2) * UNIT) begin
			step();
			check_count("fft_hold", int'(fft_hold), 0);
			check_count("sram.we_n", int'(sram.we_n), 1);
		end
		end_test("reset");

		foreach (sw_list[i]) begin
			sw_period = 3'(sw_list[i]);
			pos.hs_n = 1'b0;
			apply_reset();
			for (int k = 0; k < 3; k++) begin
				wait_hold_edge(1'b1, 2 * ref_spacing(sw_list[i]) + CAPTURE_LEN, t[k]);
			end
			if (t[0] < 0 || t[1] < 0 || t[2] < 0) begin
				report_fail("fft_hold stopped rising during the period test");
			end else begin
				check_count("sample spacing", t[1] - t[0], ref_spacing(sw_list[i]));
				check_count("sample spacing", t[2] - t[1], ref_spacing(sw_list[i]));
			end
		end
		end_test("period");

		sw_period = 3'd0;
		run = 1'b0;
		apply_reset();
		rises = 0;
		repeat (300) begin
			w.we_n = fft_hold;	// Previous hold level
			step();
			if (fft_hold && !w.we_n) rises++;
		end
		check_count("fft_hold rises", rises, 0);
		run = 1'b1;
		wait_hold_edge(1'b1, ref_spacing(0) + CAPTURE_LEN, at);
		if (at < 0) report_fail("fft_hold did not rise after run returned high");
		end_test("pause");

		sw_period = 3'd3;
		apply_reset();
		wait_hold_edge(1'b0, 2 * ref_spacing(3) + CAPTURE_LEN, t[0]);
		wait_hold_edge(1'b0, 2 * ref_spacing(3) + CAPTURE_LEN, t[1]);
		if (t[0] < 0 || t[1] < 0) report_fail("two samples were not captured");
		collect = 1'b1;
		pos.vs_n = 1'b0;
		n = 0;
		while (writes.size() < 2 * `NUM_BINS && n < 8 * `NUM_BINS) begin
			step();
			n++;
		end
		pos.vs_n = 1'b1;
		pos.hs_n = 1'b1;
		repeat (5) step();
		collect = 1'b0;
		check_count("copy writes", writes.size(), 2 * `NUM_BINS);
		for (int s = 0; s < 2; s++) begin
			for (int b = 0; b < `NUM_BINS && writes.size() > 0; b++) begin
				w = writes.pop_front();
				check_req("sram copy", w, ref_copy_req(s, b, model_mag(b, s)));
				check_mag("sram.wdata", w.wdata[`MAG_W-1:0], model_mag(b, s));
			end
		end
		end_test("copy");

		cur_offset = 2;	// Two columns written
		bar_sample = 1;	// Second sample stays at the queue head
		disp_on = 1'b1;
		repeat (60) begin
			step();
			r = $unsigned($random(seed)) % 3;
			if (r == 0) begin
				pos.x = 10'(`SPEC_X0 + $unsigned($random(seed)) % `SPEC_COLS);
				pos.y = 10'($unsigned($random(seed)) % (`SPEC_Y_MAX + 1));
			end else if (r == 1) begin
				pos.x = 10'(`BAR_X0 + $unsigned($random(seed)) % (`BAR_X1 - `BAR_X0 + 1));
				pos.y = 10'(`BAR_Y0 + $unsigned($random(seed)) % (`BAR_BASE - `BAR_Y0));
			end else begin
				pos.x = 10'($unsigned($random(seed)) % 640);
				pos.y = 10'(`SPEC_Y_MAX + 1 + $unsigned($random(seed)) % (`BAR_Y0 - 256));
			end
		end
		step();
		disp_on = 1'b0;
		repeat (2) step();
		end_test("display");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: spectro_top.f
+incdir+hdl
hdl/spectro_pkg.sv
hdl/sample_timer.sv
hdl/capture_fsm.sv
hdl/bin_store.sv
hdl/display_addresser.sv
hdl/sram_scheduler.sv
hdl/spectro_top.sv
testbench/spectro_sva.sv
testbench/tb_spectro.sv
